// File: verilog/tlb_pkg.sv
package tlb_pkg;

    // table geometry
    localparam int tlb_entries = 16;
    localparam int tlb_idx_w   = 4;

    // field widths
    localparam int vppn_w = 19;
    localparam int vpn_w  = 20;
    localparam int asid_w = 10;
    localparam int priv_w = 2;
    localparam int lo_w   = 28;
    localparam int ppn_w  = 20;
    localparam int ps_w   = 6;
    localparam int op_w   = 5;

    // page word layout
    localparam int lo_v_bit   = 0;
    localparam int lo_d_bit   = 1;
    localparam int lo_plv_lsb = 2;
    localparam int lo_mat_lsb = 4;
    localparam int lo_g_bit   = 6;
    localparam int lo_ppn_lsb = 8;

    // page size codes
    localparam logic [ps_w-1:0] ps_small = 6'd12;
    localparam logic [ps_w-1:0] ps_large = 6'd21;

    // invalidate ops
    localparam logic [op_w-1:0] inv_all0    = 5'd0;
    localparam logic [op_w-1:0] inv_all1    = 5'd1;
    localparam logic [op_w-1:0] inv_glob    = 5'd2;
    localparam logic [op_w-1:0] inv_nglob   = 5'd3;
    localparam logic [op_w-1:0] inv_asid    = 5'd4;
    localparam logic [op_w-1:0] inv_asid_va = 5'd5;
    localparam logic [op_w-1:0] inv_glob_va = 5'd6;

endpackage

// File: verilog/tlb_inv_decode.sv
`timescale 1ns/100ps

module tlb_inv_decode (
    input  logic                     inv_en,
    input  logic [tlb_pkg::op_w-1:0] inv_op,
    output logic                     sel_all,
    output logic                     sel_g,
    output logic                     sel_ng,
    output logic                     sel_asid,
    output logic                     sel_vppn,
    output logic                     inv_err
);

    logic dec_all;
    logic dec_g;
    logic dec_ng;
    logic dec_asid;
    logic dec_vppn;
    logic dec_known;

    always_comb begin
        dec_all   = 1'b0;
        dec_g     = 1'b0;
        dec_ng    = 1'b0;
        dec_asid  = 1'b0;
        dec_vppn  = 1'b0;
        dec_known = 1'b1;
        case (inv_op)
            tlb_pkg::inv_all0,
            tlb_pkg::inv_all1: begin
                dec_all = 1'b1;
            end
            tlb_pkg::inv_glob: begin
                dec_g = 1'b1;
            end
            tlb_pkg::inv_nglob: begin
                dec_ng = 1'b1;
            end
            tlb_pkg::inv_asid: begin
                dec_ng   = 1'b1;
                dec_asid = 1'b1;
            end
            tlb_pkg::inv_asid_va: begin
                dec_ng   = 1'b1;
                dec_asid = 1'b1;
                dec_vppn = 1'b1;
            end
            tlb_pkg::inv_glob_va: begin
                dec_g    = 1'b1;
                dec_asid = 1'b1;
                dec_vppn = 1'b1;
            end
            // unknown op clears nothing
            default: begin
                dec_known = 1'b0;
            end
        endcase
    end

    assign sel_all  = inv_en & dec_all;
    assign sel_g    = inv_en & dec_g;
    assign sel_ng   = inv_en & dec_ng;
    assign sel_asid = inv_en & dec_asid;
    assign sel_vppn = inv_en & dec_vppn;
    assign inv_err  = inv_en & ~dec_known;

endmodule

// File: verilog/tlb_array.sv
`timescale 1ns/100ps

module tlb_array (
    input  logic                                           clock,
    input  logic                                           arst_n,
    // write
    input  logic                                           w_en,
    input  logic [tlb_pkg::tlb_idx_w-1:0]                  w_idx,
    input  logic [tlb_pkg::vppn_w-1:0]                     w_vppn,
    input  logic [tlb_pkg::ps_w-1:0]                       w_ps,
    input  logic [tlb_pkg::asid_w-1:0]                     w_asid,
    input  logic                                           w_e,
    input  logic [tlb_pkg::lo_w-1:0]                       w_lo0,
    input  logic [tlb_pkg::lo_w-1:0]                       w_lo1,
    // invalidate
    input  logic                                           inv_en,
    input  logic [tlb_pkg::asid_w-1:0]                     inv_asid,
    input  logic [tlb_pkg::vppn_w-1:0]                     inv_vppn,
    input  logic                                           sel_all,
    input  logic                                           sel_g,
    input  logic                                           sel_ng,
    input  logic                                           sel_asid,
    input  logic                                           sel_vppn,
    // read
    input  logic [tlb_pkg::tlb_idx_w-1:0]                  r_idx,
    output logic [tlb_pkg::vppn_w-1:0]                     r_vppn,
    output logic [tlb_pkg::asid_w-1:0]                     r_asid,
    output logic [tlb_pkg::ps_w-1:0]                       r_ps,
    output logic                                           r_e,
    output logic [tlb_pkg::lo_w-1:0]                       r_lo0,
    output logic [tlb_pkg::lo_w-1:0]                       r_lo1,
    // all entries, flattened
    output logic [tlb_pkg::tlb_entries*tlb_pkg::vppn_w-1:0] ent_vppn,
    output logic [tlb_pkg::tlb_entries*tlb_pkg::asid_w-1:0] ent_asid,
    output logic [tlb_pkg::tlb_entries-1:0]                 ent_e,
    output logic [tlb_pkg::tlb_entries-1:0]                 ent_g,
    output logic [tlb_pkg::tlb_entries*tlb_pkg::lo_w-1:0]   ent_lo0,
    output logic [tlb_pkg::tlb_entries*tlb_pkg::lo_w-1:0]   ent_lo1
);

    logic [tlb_pkg::vppn_w-1:0] vppn_q [tlb_pkg::tlb_entries];
    logic [tlb_pkg::asid_w-1:0] asid_q [tlb_pkg::tlb_entries];
    logic                       ps_q   [tlb_pkg::tlb_entries];
    logic [tlb_pkg::lo_w-1:0]   lo0_q  [tlb_pkg::tlb_entries];
    logic [tlb_pkg::lo_w-1:0]   lo1_q  [tlb_pkg::tlb_entries];
    logic [tlb_pkg::tlb_entries-1:0] e_q;
    logic [tlb_pkg::tlb_entries-1:0] kill;

    logic                     w_g;
    logic [tlb_pkg::lo_w-1:0] w_lo0_m;
    logic [tlb_pkg::lo_w-1:0] w_lo1_m;

    // global only if both halves agree
    assign w_g = w_lo0[tlb_pkg::lo_g_bit] & w_lo1[tlb_pkg::lo_g_bit];

    always_comb begin
        w_lo0_m = w_lo0;
        w_lo1_m = w_lo1;
        w_lo0_m[tlb_pkg::lo_g_bit] = w_g;
        w_lo1_m[tlb_pkg::lo_g_bit] = w_g;
    end

    always_ff @(posedge clock) begin
        if (w_en) begin
            vppn_q[w_idx] <= w_vppn;
            asid_q[w_idx] <= w_asid;
            ps_q[w_idx]   <= (w_ps == tlb_pkg::ps_large);
            lo0_q[w_idx]  <= w_lo0_m;
            lo1_q[w_idx]  <= w_lo1_m;
        end
    end

    for (genvar i = 0; i < tlb_pkg::tlb_entries; i++) begin : g_ent
        logic asid_eq;
        logic vppn_eq;
        logic kind_ok;

        assign ent_g[i]  = lo0_q[i][tlb_pkg::lo_g_bit];
        assign asid_eq   = (asid_q[i] == inv_asid);
        assign vppn_eq   = (vppn_q[i] == inv_vppn);
        assign kind_ok   = (sel_g & ent_g[i]) | (sel_ng & ~ent_g[i]);
        assign kill[i]   = inv_en & (sel_all |
                           (kind_ok & (~sel_asid | asid_eq) & (~sel_vppn | vppn_eq)));

        assign ent_vppn[i*tlb_pkg::vppn_w +: tlb_pkg::vppn_w] = vppn_q[i];
        assign ent_asid[i*tlb_pkg::asid_w +: tlb_pkg::asid_w] = asid_q[i];
        assign ent_lo0[i*tlb_pkg::lo_w +: tlb_pkg::lo_w]      = lo0_q[i];
        assign ent_lo1[i*tlb_pkg::lo_w +: tlb_pkg::lo_w]      = lo1_q[i];
    end

    // invalidate beats a write to the same slot
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            e_q <= '0;
        end else begin
            for (int i = 0; i < tlb_pkg::tlb_entries; i++) begin
                if (kill[i]) begin
                    e_q[i] <= 1'b0;
                end else if (w_en && (w_idx == tlb_pkg::tlb_idx_w'(i))) begin
                    e_q[i] <= w_e;
                end
            end
        end
    end

    assign ent_e = e_q;

    assign r_vppn = vppn_q[r_idx];
    assign r_asid = asid_q[r_idx];
    assign r_ps   = ps_q[r_idx] ? tlb_pkg::ps_large : tlb_pkg::ps_small;
    assign r_e    = e_q[r_idx];
    assign r_lo0  = lo0_q[r_idx];
    assign r_lo1  = lo1_q[r_idx];

endmodule

// File: verilog/tlb_match.sv
`timescale 1ns/100ps

module tlb_match (
    input  logic [tlb_pkg::vpn_w-1:0]                       vpn,
    input  logic [tlb_pkg::asid_w-1:0]                      asid,
    input  logic [tlb_pkg::tlb_entries*tlb_pkg::vppn_w-1:0] ent_vppn,
    input  logic [tlb_pkg::tlb_entries*tlb_pkg::asid_w-1:0] ent_asid,
    input  logic [tlb_pkg::tlb_entries-1:0]                 ent_e,
    input  logic [tlb_pkg::tlb_entries-1:0]                 ent_g,
    output logic                                            hit,
    output logic [tlb_pkg::tlb_idx_w-1:0]                   idx
);

    logic [tlb_pkg::tlb_entries-1:0] hit_vec;

    // vpn bit 0 only picks even/odd page
    for (genvar i = 0; i < tlb_pkg::tlb_entries; i++) begin : g_cmp
        assign hit_vec[i] = ent_e[i]
            & (ent_vppn[i*tlb_pkg::vppn_w +: tlb_pkg::vppn_w] == vpn[tlb_pkg::vpn_w-1:1])
            & (ent_g[i] | (ent_asid[i*tlb_pkg::asid_w +: tlb_pkg::asid_w] == asid));
    end

    assign hit = |hit_vec;

    // lowest index wins
    always_comb begin
        idx = '0;
        for (int i = tlb_pkg::tlb_entries - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                idx = tlb_pkg::tlb_idx_w'(i);
            end
        end
    end

endmodule

// File: verilog/tlb_translate.sv
`timescale 1ns/100ps

module tlb_translate (
    input  logic                                          clock,
    input  logic                                          arst_n,
    input  logic                                          vpn_odd,
    input  logic [tlb_pkg::priv_w-1:0]                    priv,
    input  logic                                          hit,
    input  logic [tlb_pkg::tlb_idx_w-1:0]                 idx,
    input  logic [tlb_pkg::tlb_entries*tlb_pkg::lo_w-1:0] ent_lo0,
    input  logic [tlb_pkg::tlb_entries*tlb_pkg::lo_w-1:0] ent_lo1,
    output logic [tlb_pkg::tlb_idx_w-1:0]                 pidx,
    output logic                                          valid,
    output logic                                          unpriv,
    output logic                                          uncached,
    output logic                                          dirty,
    output logic [tlb_pkg::ppn_w-1:0]                     ppn
);

    logic                          hit_q;
    logic [tlb_pkg::tlb_idx_w-1:0] idx_q;
    logic                          odd_q;
    logic [tlb_pkg::priv_w-1:0]    priv_q;
    logic [tlb_pkg::lo_w-1:0]      word;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit;
        end
    end

    always_ff @(posedge clock) begin
        idx_q  <= idx;
        odd_q  <= vpn_odd;
        priv_q <= priv;
    end

    // page word comes from the current array state
    assign word = odd_q ? ent_lo1[idx_q*tlb_pkg::lo_w +: tlb_pkg::lo_w]
                        : ent_lo0[idx_q*tlb_pkg::lo_w +: tlb_pkg::lo_w];

    assign pidx     = idx_q;
    assign valid    = hit_q & word[tlb_pkg::lo_v_bit];
    assign unpriv   = (word[tlb_pkg::lo_plv_lsb +: tlb_pkg::priv_w] < priv_q);
    assign uncached = (word[tlb_pkg::lo_mat_lsb +: 2] == 2'd0);
    assign dirty    = word[tlb_pkg::lo_d_bit];
    assign ppn      = word[tlb_pkg::lo_ppn_lsb +: tlb_pkg::ppn_w];

endmodule

// File: verilog/tlb_top.sv
`timescale 1ns/100ps

module tlb_top (
    input  logic                          clock,
    input  logic                          arst_n,
    // fetch lookup
    input  logic [tlb_pkg::vpn_w-1:0]     if_vpn,
    input  logic [tlb_pkg::asid_w-1:0]    if_asid,
    input  logic [tlb_pkg::priv_w-1:0]    if_priv,
    output logic [tlb_pkg::tlb_idx_w-1:0] if_idx,
    output logic                          if_valid,
    output logic                          if_unpriv,
    output logic                          if_uncached,
    output logic                          if_dirty,
    output logic [tlb_pkg::ppn_w-1:0]     if_ppn,
    // load/store lookup
    input  logic [tlb_pkg::vpn_w-1:0]     ls_vpn,
    input  logic [tlb_pkg::asid_w-1:0]    ls_asid,
    input  logic [tlb_pkg::priv_w-1:0]    ls_priv,
    output logic [tlb_pkg::tlb_idx_w-1:0] ls_idx,
    output logic                          ls_valid,
    output logic                          ls_unpriv,
    output logic                          ls_uncached,
    output logic                          ls_dirty,
    output logic [tlb_pkg::ppn_w-1:0]     ls_ppn,
    // entry write
    input  logic                          w_en,
    input  logic [tlb_pkg::tlb_idx_w-1:0] w_idx,
    input  logic [tlb_pkg::vppn_w-1:0]    w_vppn,
    input  logic [tlb_pkg::ps_w-1:0]      w_ps,
    input  logic [tlb_pkg::asid_w-1:0]    w_asid,
    input  logic                          w_e,
    input  logic [tlb_pkg::lo_w-1:0]      w_lo0,
    input  logic [tlb_pkg::lo_w-1:0]      w_lo1,
    // entry read
    input  logic [tlb_pkg::tlb_idx_w-1:0] r_idx,
    output logic [tlb_pkg::vppn_w-1:0]    r_vppn,
    output logic [tlb_pkg::asid_w-1:0]    r_asid,
    output logic [tlb_pkg::ps_w-1:0]      r_ps,
    output logic                          r_e,
    output logic [tlb_pkg::lo_w-1:0]      r_lo0,
    output logic [tlb_pkg::lo_w-1:0]      r_lo1,
    // invalidate
    input  logic                          inv_en,
    input  logic [tlb_pkg::op_w-1:0]      inv_op,
    input  logic [tlb_pkg::asid_w-1:0]    inv_asid,
    input  logic [tlb_pkg::vppn_w-1:0]    inv_vppn,
    output logic                          inv_err
);

    logic sel_all;
    logic sel_g;
    logic sel_ng;
    logic sel_asid;
    logic sel_vppn;

    logic [tlb_pkg::tlb_entries*tlb_pkg::vppn_w-1:0] ent_vppn;
    logic [tlb_pkg::tlb_entries*tlb_pkg::asid_w-1:0] ent_asid;
    logic [tlb_pkg::tlb_entries-1:0]                 ent_e;
    logic [tlb_pkg::tlb_entries-1:0]                 ent_g;
    logic [tlb_pkg::tlb_entries*tlb_pkg::lo_w-1:0]   ent_lo0;
    logic [tlb_pkg::tlb_entries*tlb_pkg::lo_w-1:0]   ent_lo1;

    logic                          if_hit;
    logic [tlb_pkg::tlb_idx_w-1:0] if_hit_idx;
    logic                          ls_hit;
    logic [tlb_pkg::tlb_idx_w-1:0] ls_hit_idx;

    tlb_inv_decode inv_dec (
        .inv_en   (inv_en),
        .inv_op   (inv_op),
        .sel_all  (sel_all),
        .sel_g    (sel_g),
        .sel_ng   (sel_ng),
        .sel_asid (sel_asid),
        .sel_vppn (sel_vppn),
        .inv_err  (inv_err)
    );

    tlb_array array (
        .clock    (clock),
        .arst_n   (arst_n),
        .w_en     (w_en),
        .w_idx    (w_idx),
        .w_vppn   (w_vppn),
        .w_ps     (w_ps),
        .w_asid   (w_asid),
        .w_e      (w_e),
        .w_lo0    (w_lo0),
        .w_lo1    (w_lo1),
        .inv_en   (inv_en),
        .inv_asid (inv_asid),
        .inv_vppn (inv_vppn),
        .sel_all  (sel_all),
        .sel_g    (sel_g),
        .sel_ng   (sel_ng),
        .sel_asid (sel_asid),
        .sel_vppn (sel_vppn),
        .r_idx    (r_idx),
        .r_vppn   (r_vppn),
        .r_asid   (r_asid),
        .r_ps     (r_ps),
        .r_e      (r_e),
        .r_lo0    (r_lo0),
        .r_lo1    (r_lo1),
        .ent_vppn (ent_vppn),
        .ent_asid (ent_asid),
        .ent_e    (ent_e),
        .ent_g    (ent_g),
        .ent_lo0  (ent_lo0),
        .ent_lo1  (ent_lo1)
    );

    tlb_match if_match (
        .vpn      (if_vpn),
        .asid     (if_asid),
        .ent_vppn (ent_vppn),
        .ent_asid (ent_asid),
        .ent_e    (ent_e),
        .ent_g    (ent_g),
        .hit      (if_hit),
        .idx      (if_hit_idx)
    );

    tlb_match ls_match (
        .vpn      (ls_vpn),
        .asid     (ls_asid),
        .ent_vppn (ent_vppn),
        .ent_asid (ent_asid),
        .ent_e    (ent_e),
        .ent_g    (ent_g),
        .hit      (ls_hit),
        .idx      (ls_hit_idx)
    );

    tlb_translate if_xlate (
        .clock    (clock),
        .arst_n   (arst_n),
        .vpn_odd  (if_vpn[0]),
        .priv     (if_priv),
        .hit      (if_hit),
        .idx      (if_hit_idx),
        .ent_lo0  (ent_lo0),
        .ent_lo1  (ent_lo1),
        .pidx     (if_idx),
        .valid    (if_valid),
        .unpriv   (if_unpriv),
        .uncached (if_uncached),
        .dirty    (if_dirty),
        .ppn      (if_ppn)
    );

    tlb_translate ls_xlate (
        .clock    (clock),
        .arst_n   (arst_n),
        .vpn_odd  (ls_vpn[0]),
        .priv     (ls_priv),
        .hit      (ls_hit),
        .idx      (ls_hit_idx),
        .ent_lo0  (ent_lo0),
        .ent_lo1  (ent_lo1),
        .pidx     (ls_idx),
        .valid    (ls_valid),
        .unpriv   (ls_unpriv),
        .uncached (ls_uncached),
        .dirty    (ls_dirty),
        .ppn      (ls_ppn)
    );

endmodule

// File: tb/tlb_model.svh
// reference copy of the table with g merged into both words
logic [tlb_pkg::vppn_w-1:0] m_vppn [tlb_pkg::tlb_entries];
logic [tlb_pkg::asid_w-1:0] m_asid [tlb_pkg::tlb_entries];
logic                       m_ps   [tlb_pkg::tlb_entries];
logic [tlb_pkg::lo_w-1:0]   m_lo0  [tlb_pkg::tlb_entries];
logic [tlb_pkg::lo_w-1:0]   m_lo1  [tlb_pkg::tlb_entries];
logic [tlb_pkg::tlb_entries-1:0] m_e;

function automatic void model_write(input int idx, input logic [18:0] vppn,
                                    input logic [5:0] ps, input logic [9:0] asid,
                                    input logic e, input logic [27:0] lo0,
                                    input logic [27:0] lo1);
    logic g;
    g = lo0[tlb_pkg::lo_g_bit] & lo1[tlb_pkg::lo_g_bit];
    m_vppn[idx] = vppn;
    m_asid[idx] = asid;
    m_ps[idx]   = (ps == 6'd21);
    m_e[idx]    = e;
    m_lo0[idx]  = lo0;
    m_lo1[idx]  = lo1;
    m_lo0[idx][tlb_pkg::lo_g_bit] = g;
    m_lo1[idx][tlb_pkg::lo_g_bit] = g;
endfunction

// entries an invalidate would clear in the current table
function automatic logic [15:0] model_inv(input int op, input logic [9:0] asid,
                                          input logic [18:0] vppn);
    logic [15:0] mask;
    logic        g;
    mask = '0;
    for (int i = 0; i < 16; i++) begin
        g = m_lo0[i][tlb_pkg::lo_g_bit];
        case (op)
            0, 1: mask[i] = 1'b1;
            2: mask[i] = g;
            3: mask[i] = !g;
            4: mask[i] = !g && (m_asid[i] == asid);
            5: mask[i] = !g && (m_asid[i] == asid) && (m_vppn[i] == vppn);
            6: mask[i] = g && (m_asid[i] == asid) && (m_vppn[i] == vppn);
            default: mask[i] = 1'b0;
        endcase
    end
    return mask;
endfunction

function automatic void model_lookup(input logic [19:0] vpn, input logic [9:0] asid,
                                     input logic [1:0] priv, output logic hit,
                                     output logic [3:0] idx, output logic valid,
                                     output logic [19:0] ppn, output logic uncached,
                                     output logic dirty, output logic unpriv);
    logic [27:0] word;
    hit = 1'b0;
    idx = '0;
    for (int i = 15; i >= 0; i--) begin
        if (m_e[i] && m_vppn[i] == vpn[19:1]
            && (m_lo0[i][tlb_pkg::lo_g_bit] || m_asid[i] == asid)) begin
            hit = 1'b1;
            idx = 4'(i);
        end
    end
    word     = vpn[0] ? m_lo1[idx] : m_lo0[idx];
    valid    = hit & word[0];
    dirty    = word[1];
    unpriv   = word[3:2] < priv;
    uncached = (word[5:4] == 2'd0);
    ppn      = word[27:8];
endfunction

// File: tb/tlb_tb.sv
`timescale 1ns/100ps

module tlb_tb;

    localparam int fill_cycles = 16;
    localparam int max_cycles  = 40 + 2 * 16 + 12 + 8 + 7 * 50 + 60 + 400;

    logic        clock;
    logic        arst_n;
    logic [19:0] if_vpn, ls_vpn;
    logic [9:0]  if_asid, ls_asid;
    logic [1:0]  if_priv, ls_priv;
    logic [3:0]  if_idx, ls_idx;
    logic        if_valid, if_unpriv, if_uncached, if_dirty;
    logic        ls_valid, ls_unpriv, ls_uncached, ls_dirty;
    logic [19:0] if_ppn, ls_ppn;
    logic        w_en, w_e;
    logic [3:0]  w_idx;
    logic [18:0] w_vppn;
    logic [5:0]  w_ps;
    logic [9:0]  w_asid;
    logic [27:0] w_lo0, w_lo1;
    logic [3:0]  r_idx;
    logic [18:0] r_vppn;
    logic [9:0]  r_asid;
    logic [5:0]  r_ps;
    logic        r_e;
    logic [27:0] r_lo0, r_lo1;
    logic        inv_en;
    logic [4:0]  inv_op;
    logic [9:0]  inv_asid;
    logic [18:0] inv_vppn;
    logic        inv_err;

    integer seed;
    int     errors;
    int     tests_run;
    int     tests_bad;
    logic   pend_if;
    logic   pend_ls;

    `include "tlb_model.svh"

    tlb_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_bad++;
            $display("test %s: FAILED", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // checks one port's result one edge after its request
    task automatic verify_port(input string p, input logic [19:0] vpn, input logic [9:0] asid,
                               input logic [1:0] priv, input logic [3:0] a_idx,
                               input logic a_valid, input logic [19:0] a_ppn,
                               input logic a_unc, input logic a_dirty, input logic a_unp);
        logic        hit, valid, unc, dirty, unp;
        logic [3:0]  idx;
        logic [19:0] ppn;
        model_lookup(vpn, asid, priv, hit, idx, valid, ppn, unc, dirty, unp);
        check_val({p, "_valid"}, 32'(valid), 32'(a_valid));
        if (hit) begin
            check_val({p, "_idx"}, 32'(idx), 32'(a_idx));
            check_val({p, "_ppn"}, 32'(ppn), 32'(a_ppn));
            check_val({p, "_uncached"}, 32'(unc), 32'(a_unc));
            check_val({p, "_dirty"}, 32'(dirty), 32'(a_dirty));
            check_val({p, "_unpriv"}, 32'(unp), 32'(a_unp));
        end
    endtask

    initial begin : compare
        logic do_if;
        logic do_ls;
        forever begin
            @(posedge clock);
            do_if = pend_if;
            do_ls = pend_ls;
            // outputs settle after the edge
            #1;
            if (do_if) begin
                verify_port("if", if_vpn, if_asid, if_priv, if_idx, if_valid,
                            if_ppn, if_uncached, if_dirty, if_unpriv);
            end
            if (do_ls) begin
                verify_port("ls", ls_vpn, ls_asid, ls_priv, ls_idx, ls_valid,
                            ls_ppn, ls_uncached, ls_dirty, ls_unpriv);
            end
        end
    end

    task automatic next_cycle();
        @(negedge clock);
        w_en    = 1'b0;
        inv_en  = 1'b0;
        pend_if = 1'b0;
        pend_ls = 1'b0;
    endtask

    task automatic write_entry(input int idx, input logic [18:0] vppn, input logic [5:0] ps,
                               input logic [9:0] asid, input logic e,
                               input logic [27:0] lo0, input logic [27:0] lo1);
        next_cycle();
        w_en = 1'b1;
        w_idx = 4'(idx);
        w_vppn = vppn;
        w_ps = ps;
        w_asid = asid;
        w_e = e;
        w_lo0 = lo0;
        w_lo1 = lo1;
        model_write(idx, vppn, ps, asid, e, lo0, lo1);
    endtask

    task automatic read_check(input int idx);
        next_cycle();
        r_idx = 4'(idx);
        #1;
        check_val("r_vppn", 32'(m_vppn[idx]), 32'(r_vppn));
        check_val("r_asid", 32'(m_asid[idx]), 32'(r_asid));
        check_val("r_ps", m_ps[idx] ? 32'd21 : 32'd12, 32'(r_ps));
        check_val("r_e", 32'(m_e[idx]), 32'(r_e));
        check_val("r_lo0", 32'(m_lo0[idx]), 32'(r_lo0));
        check_val("r_lo1", 32'(m_lo1[idx]), 32'(r_lo1));
    endtask

    task automatic lookup(input logic [19:0] ivpn, input logic [9:0] iasid,
                          input logic [1:0] ipriv, input logic [19:0] lvpn,
                          input logic [9:0] lasid, input logic [1:0] lpriv);
        next_cycle();
        if_vpn = ivpn;
        if_asid = iasid;
        if_priv = ipriv;
        ls_vpn = lvpn;
        ls_asid = lasid;
        ls_priv = lpriv;
        pend_if = 1'b1;
        pend_ls = 1'b1;
    endtask

    task automatic invalidate(input int op, input logic [9:0] asid, input logic [18:0] vppn);
        logic [15:0] mask;
        next_cycle();
        inv_en = 1'b1;
        inv_op = 5'(op);
        inv_asid = asid;
        inv_vppn = vppn;
        mask = model_inv(op, asid, vppn);
        m_e = m_e & ~mask;
        #1;
        check_val("inv_err", (op > 6) ? 32'd1 : 32'd0, 32'(inv_err));
    endtask

    // mixed table with global even slots and asids changing every two slots
    task automatic fill_mixed();
        logic [27:0] g;
        for (int i = 0; i < fill_cycles; i++) begin
            g = (i % 2 == 0) ? 28'h40 : 28'h0;
            write_entry(i, 19'h10 + 19'(i % 3), 6'd12, 10'(1 + (i / 2) % 2), 1'b1,
                        28'h0000135 | g | 28'(i << 8), 28'h0000211 | g | 28'(i << 12));
        end
    endtask

    initial begin : watchdog
        #(max_cycles * 4 + 200);
        $display("simulation timed out before all tests finished");
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        int          e0;
        logic [31:0] r;
        logic [31:0] q;
        logic [15:0] mask;
        seed = 43;
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        pend_if = 1'b0;
        pend_ls = 1'b0;
        arst_n = 1'b0;
        {if_vpn, ls_vpn, if_asid, ls_asid, if_priv, ls_priv} = '0;
        {w_en, w_e, w_idx, w_vppn, w_ps, w_asid, w_lo0, w_lo1} = '0;
        {r_idx, inv_en, inv_op, inv_asid, inv_vppn} = '0;
        m_e = '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            lookup(r[19:0], r[29:20], 2'd0, r[20:1], r[31:22], 2'd3);
        end
        next_cycle();
        end_test("reset_lookup", e0);

        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            q = $random(seed);
            write_entry(i, r[18:0], (i % 3 == 0) ? 6'd21 : ((i % 3 == 1) ? 6'd12 : 6'd7),
                        q[9:0], r[19], q[27:0], {r[31:20], q[31:16]});
        end
        for (int i = 0; i < 16; i++) read_check(i);
        end_test("write_read", e0);

        e0 = errors;
        invalidate(0, 10'd0, 19'd0);
        write_entry(2, 19'h100, 6'd12, 10'd5, 1'b1, 28'hABCDE01, 28'h1234533);
        write_entry(3, 19'h200, 6'd12, 10'd7, 1'b1, 28'h5555579, 28'h66666FF);
        write_entry(6, 19'h100, 6'd12, 10'd5, 1'b1, 28'h7777701, 28'h7777701);
        lookup({19'h100, 1'b0}, 10'd5, 2'd0, {19'h100, 1'b1}, 10'd5, 2'd3);
        lookup({19'h200, 1'b0}, 10'd9, 2'd1, {19'h200, 1'b1}, 10'd9, 2'd3);
        lookup({19'h100, 1'b0}, 10'd9, 2'd0, {19'h300, 1'b1}, 10'd5, 2'd0);
        next_cycle();
        end_test("lookup", e0);

        e0 = errors;
        write_entry(4, 19'h300, 6'd12, 10'd5, 1'b0, 28'h1111101, 28'h2222201);
        write_entry(5, 19'h301, 6'd12, 10'd5, 1'b1, 28'h1111101, 28'h2222200);
        lookup({19'h300, 1'b0}, 10'd5, 2'd0, {19'h301, 1'b1}, 10'd5, 2'd0);
        lookup({19'h300, 1'b1}, 10'd5, 2'd0, {19'h301, 1'b0}, 10'd5, 2'd0);
        next_cycle();
        end_test("no_exist_no_valid", e0);

        e0 = errors;
        for (int op = 0; op <= 6; op++) begin
            fill_mixed();
            invalidate(op, 10'd1, 19'h10);
            for (int i = 0; i < 16; i++) read_check(i);
            for (int i = 0; i < 16; i++) begin
                lookup({m_vppn[i], 1'(i)}, m_asid[i], 2'd0, {m_vppn[i], 1'(~i)}, 10'd2, 2'd2);
            end
        end
        next_cycle();
        end_test("invalidate_ops", e0);

        e0 = errors;
        fill_mixed();
        for (int op = 7; op < 32; op++) invalidate(op, 10'd1, 19'h10);
        for (int i = 0; i < 16; i++) read_check(i);
        end_test("illegal_ops", e0);

        e0 = errors;
        for (int c = 0; c < 400; c++) begin
            next_cycle();
            r = $random(seed);
            q = $random(seed);
            if_vpn = {16'h0, r[2:0], r[3]};
            if_asid = {8'h0, r[5:4]};
            if_priv = r[7:6];
            ls_vpn = {16'h0, r[10:8], r[11]};
            ls_asid = {8'h0, r[13:12]};
            ls_priv = r[15:14];
            mask = '0;
            if (r[17:16] == 2'd0) begin
                inv_en = 1'b1;
                inv_op = 5'(q[7:0] % 7);
                inv_asid = {8'h0, q[9:8]};
                inv_vppn = {16'h0, q[12:10]};
                mask = model_inv(int'(inv_op), inv_asid, inv_vppn);
            end
            if (r[19:18] != 2'd0) begin
                w_en = 1'b1;
                w_idx = q[19:16];
                w_vppn = {16'h0, q[22:20]};
                w_ps = q[23] ? 6'd21 : 6'd12;
                w_asid = {8'h0, q[25:24]};
                w_e = q[26] | q[27];
                w_lo0 = {r[31:20], q[31:28], 4'h0, r[23:16]};
                w_lo1 = {q[31:16], r[31:24], q[7:4]};
                model_write(int'(w_idx), w_vppn, w_ps, w_asid, w_e, w_lo0, w_lo1);
            end
            m_e = m_e & ~mask;
            pend_if = !w_en && !inv_en;
            pend_ls = !w_en && !inv_en;
        end
        next_cycle();
        for (int i = 0; i < 16; i++) read_check(i);
        end_test("random", e0);

        next_cycle();
        $display("tests run %0d, failing %0d, check errors %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+tb
verilog/tlb_pkg.sv
verilog/tlb_inv_decode.sv
verilog/tlb_array.sv
verilog/tlb_match.sv
verilog/tlb_translate.sv
verilog/tlb_top.sv
tb/tlb_tb.sv

// File: run.sh
#!/bin/bash
# build and run the TLB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tlb_tb -o tlb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tlb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1
